/* src/bridge_pkg.sv */
//--------------------------------------------------------------------
// shared widths, types and AXI constants of the data-side bridge
// referenced by scoped name from every RTL file of the bridge
//--------------------------------------------------------------------
`default_nettype none

package bridge_pkg;

	//--------------------------------------------------------------------
	// widths
	//--------------------------------------------------------------------
	localparam int word_bits  = 32;		// AXI data bus width
	localparam int line_beats = 16;		// beats per cache line burst

	//--------------------------------------------------------------------
	// payload and field types
	//--------------------------------------------------------------------
	typedef logic [31:0]                       addr_t;	// byte address
	typedef logic [word_bits-1:0]              word_t;	// one beat / one uncached datum
	typedef logic [word_bits/8-1:0]            strb_t;	// byte strobe of one beat
	typedef logic [2:0]                        size_t;	// AXI size code
	typedef logic [3:0]                        len_t;	// burst length minus one
	typedef logic [3:0]                        axi_id_t;
	typedef logic [line_beats*word_bits-1:0]   line_t;	// one cache line, low word first

	//--------------------------------------------------------------------
	// AXI IDs, one per data-side port
	//--------------------------------------------------------------------
	localparam axi_id_t id_line = 4'd3;	// cached line port
	localparam axi_id_t id_word = 4'd2;	// uncached word port

endpackage

`default_nettype wire

/* src/port_channel.sv */
//--------------------------------------------------------------------
// per-port transaction controller of the bridge
// captures one read or write request in free, issues it on the AR/AW
// side and serialises the captured payload into 32-bit W beats
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module port_channel #(
	parameter type payload_t = bridge_pkg::word_t	// line_t for bursts, word_t for singles
) (
	input  logic               clk,
	input  logic               rst,
	// cache controller side
	input  logic               rd_req,
	input  bridge_pkg::size_t  rd_size,
	input  bridge_pkg::addr_t  rd_addr,
	output logic               rd_rdy,
	output logic               ret_valid,
	output logic               ret_last,
	input  logic               wr_req,
	input  bridge_pkg::size_t  wr_size,
	input  bridge_pkg::addr_t  wr_addr,
	input  bridge_pkg::strb_t  wr_strb,
	input  payload_t           wr_data,
	output logic               wr_rdy,
	// read address
	output logic               ar_valid,
	output bridge_pkg::addr_t  ar_addr,
	output bridge_pkg::size_t  ar_size,
	output bridge_pkg::len_t   ar_len,
	input  logic               ar_ready,
	// write address
	output logic               aw_valid,
	output bridge_pkg::addr_t  aw_addr,
	output bridge_pkg::size_t  aw_size,
	output bridge_pkg::len_t   aw_len,
	input  logic               aw_ready,
	// write data
	output logic               w_valid,
	output bridge_pkg::word_t  w_data,
	output bridge_pkg::strb_t  w_strb,
	output logic               w_last,
	input  logic               w_ready,
	// responses already decoded by ID
	input  logic               r_hit,
	input  logic               r_last,
	input  logic               b_hit
);

	localparam int word_bits = $bits(bridge_pkg::word_t);
	localparam int beats     = $bits(payload_t) / word_bits;
	localparam int cnt_bits  = (beats > 1) ? $clog2(beats) : 1;

	typedef enum logic [2:0] {
		st_free,
		st_rd_req,
		st_rd_res,
		st_wr_req,
		st_wr_data,
		st_wr_res
	} state_t;

	state_t                state;
	state_t                state_nxt;
	bridge_pkg::addr_t     rd_addr_q;
	bridge_pkg::size_t     rd_size_q;
	bridge_pkg::addr_t     wr_addr_q;
	bridge_pkg::size_t     wr_size_q;
	bridge_pkg::strb_t     wr_strb_q;
	payload_t              wr_buf;		// shifts down one word per beat
	logic [cnt_bits-1:0]   beat_cnt;
	logic                  w_fire;

	assign w_fire = w_valid & w_ready;

	//--------------------------------------------------------------------
	// transaction FSM
	//--------------------------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			st_free:
			begin
				if (rd_req)
					state_nxt = st_rd_req;	// reads win a same-cycle tie
				else if (wr_req)
					state_nxt = st_wr_req;
			end
			st_rd_req:
				if (ar_ready)
					state_nxt = st_rd_res;
			st_rd_res:
				if (r_hit & r_last)
					state_nxt = st_free;
			st_wr_req:
				if (aw_ready)
					state_nxt = st_wr_data;
			st_wr_data:
				if (w_ready & w_last)
					state_nxt = st_wr_res;
			st_wr_res:
				if (b_hit)
					state_nxt = st_free;
			default:
				state_nxt = st_free;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= st_free;
		else
			state <= state_nxt;
	end

	//--------------------------------------------------------------------
	// request capture and beat serialisation
	//--------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (state == st_free && rd_req)
		begin
			rd_addr_q <= rd_addr;
			rd_size_q <= rd_size;
		end
		if (wr_rdy && wr_req)
		begin
			wr_addr_q <= wr_addr;
			wr_size_q <= wr_size;
			wr_strb_q <= wr_strb;
			wr_buf    <= wr_data;
		end
		else if (w_fire)
			wr_buf <= wr_buf >> word_bits;	// next word moves to the bottom
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			beat_cnt <= '0;
		else if (state == st_free)
			beat_cnt <= '0;
		else if (w_fire)
			beat_cnt <= beat_cnt + 1'b1;
	end

	assign rd_rdy    = (state == st_free);
	assign wr_rdy    = (state == st_free) & ~rd_req;	// a write waits behind a same-cycle read
	assign ret_valid = r_hit & (state == st_rd_res);
	assign ret_last  = ret_valid & r_last;

	assign ar_valid = (state == st_rd_req);
	assign ar_addr  = rd_addr_q;
	assign ar_size  = rd_size_q;
	assign ar_len   = bridge_pkg::len_t'(beats - 1);

	assign aw_valid = (state == st_wr_req);
	assign aw_addr  = wr_addr_q;
	assign aw_size  = wr_size_q;
	assign aw_len   = bridge_pkg::len_t'(beats - 1);

	assign w_valid = (state == st_wr_data);
	assign w_data  = wr_buf[word_bits-1:0];
	assign w_strb  = wr_strb_q;
	assign w_last  = (beat_cnt == cnt_bits'(beats - 1));

endmodule

`default_nettype wire

/* src/axi_port_mux.sv */
//--------------------------------------------------------------------
// merges the line and word controllers onto one AXI master port
// AR and AW use fixed priority to the line port, W follows the AW
// winner until wlast, responses are steered back by ID
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_port_mux (
	input  logic                 clk,
	input  logic                 rst,
	// line controller
	input  logic                 ln_ar_valid,
	input  bridge_pkg::addr_t    ln_ar_addr,
	input  bridge_pkg::size_t    ln_ar_size,
	input  bridge_pkg::len_t     ln_ar_len,
	input  logic                 ln_aw_valid,
	input  bridge_pkg::addr_t    ln_aw_addr,
	input  bridge_pkg::size_t    ln_aw_size,
	input  bridge_pkg::len_t     ln_aw_len,
	input  logic                 ln_w_valid,
	input  bridge_pkg::word_t    ln_w_data,
	input  bridge_pkg::strb_t    ln_w_strb,
	input  logic                 ln_w_last,
	output logic                 ln_ar_ready,
	output logic                 ln_aw_ready,
	output logic                 ln_w_ready,
	output logic                 ln_r_hit,
	output logic                 ln_b_hit,
	// word controller
	input  logic                 wd_ar_valid,
	input  bridge_pkg::addr_t    wd_ar_addr,
	input  bridge_pkg::size_t    wd_ar_size,
	input  bridge_pkg::len_t     wd_ar_len,
	input  logic                 wd_aw_valid,
	input  bridge_pkg::addr_t    wd_aw_addr,
	input  bridge_pkg::size_t    wd_aw_size,
	input  bridge_pkg::len_t     wd_aw_len,
	input  logic                 wd_w_valid,
	input  bridge_pkg::word_t    wd_w_data,
	input  bridge_pkg::strb_t    wd_w_strb,
	input  logic                 wd_w_last,
	output logic                 wd_ar_ready,
	output logic                 wd_aw_ready,
	output logic                 wd_w_ready,
	output logic                 wd_r_hit,
	output logic                 wd_b_hit,
	// AXI master
	output bridge_pkg::axi_id_t  arid,
	output bridge_pkg::addr_t    araddr,
	output bridge_pkg::len_t     arlen,
	output bridge_pkg::size_t    arsize,
	output logic                 arvalid,
	input  logic                 arready,
	input  bridge_pkg::axi_id_t  rid,
	input  logic                 rlast,
	input  logic                 rvalid,
	output logic                 rready,
	output bridge_pkg::axi_id_t  awid,
	output bridge_pkg::addr_t    awaddr,
	output bridge_pkg::len_t     awlen,
	output bridge_pkg::size_t    awsize,
	output logic                 awvalid,
	input  logic                 awready,
	output bridge_pkg::word_t    wdata,
	output bridge_pkg::strb_t    wstrb,
	output logic                 wlast,
	output logic                 wvalid,
	input  logic                 wready,
	input  bridge_pkg::axi_id_t  bid,
	input  logic                 bvalid,
	output logic                 bready
);

	logic ar_lock;		// AR grant held while arvalid waits
	logic ar_lock_wd;
	logic ar_pick_wd;
	logic aw_lock;
	logic aw_lock_wd;
	logic aw_pick_wd;
	logic w_busy;		// W channel owned by the last AW winner
	logic w_owner_wd;

	//--------------------------------------------------------------------
	// read address channel
	//--------------------------------------------------------------------
	assign ar_pick_wd  = ar_lock ? ar_lock_wd : ~ln_ar_valid;
	assign arvalid     = ar_pick_wd ? wd_ar_valid : ln_ar_valid;
	assign arid        = ar_pick_wd ? bridge_pkg::id_word : bridge_pkg::id_line;
	assign araddr      = ar_pick_wd ? wd_ar_addr : ln_ar_addr;
	assign arsize      = ar_pick_wd ? wd_ar_size : ln_ar_size;
	assign arlen       = ar_pick_wd ? wd_ar_len : ln_ar_len;
	assign ln_ar_ready = arready & ~ar_pick_wd;
	assign wd_ar_ready = arready & ar_pick_wd;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			ar_lock    <= 1'b0;
			ar_lock_wd <= 1'b0;
		end
		else if (arvalid && arready)
			ar_lock <= 1'b0;
		else if (arvalid)
		begin
			ar_lock    <= 1'b1;	// keep the same port while the slave stalls
			ar_lock_wd <= ar_pick_wd;
		end
	end

	//--------------------------------------------------------------------
	// write address channel closed while a W burst is open
	//--------------------------------------------------------------------
	assign aw_pick_wd  = aw_lock ? aw_lock_wd : ~ln_aw_valid;
	assign awvalid     = ~w_busy & (aw_pick_wd ? wd_aw_valid : ln_aw_valid);
	assign awid        = aw_pick_wd ? bridge_pkg::id_word : bridge_pkg::id_line;
	assign awaddr      = aw_pick_wd ? wd_aw_addr : ln_aw_addr;
	assign awsize      = aw_pick_wd ? wd_aw_size : ln_aw_size;
	assign awlen       = aw_pick_wd ? wd_aw_len : ln_aw_len;
	assign ln_aw_ready = awready & ~w_busy & ~aw_pick_wd;
	assign wd_aw_ready = awready & ~w_busy & aw_pick_wd;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			aw_lock    <= 1'b0;
			aw_lock_wd <= 1'b0;
		end
		else if (awvalid && awready)
			aw_lock <= 1'b0;
		else if (awvalid)
		begin
			aw_lock    <= 1'b1;
			aw_lock_wd <= aw_pick_wd;
		end
	end

	//--------------------------------------------------------------------
	// write data channel
	//--------------------------------------------------------------------
	assign wvalid     = w_busy & (w_owner_wd ? wd_w_valid : ln_w_valid);
	assign wdata      = w_owner_wd ? wd_w_data : ln_w_data;
	assign wstrb      = w_owner_wd ? wd_w_strb : ln_w_strb;
	assign wlast      = w_owner_wd ? wd_w_last : ln_w_last;
	assign ln_w_ready = wready & w_busy & ~w_owner_wd;
	assign wd_w_ready = wready & w_busy & w_owner_wd;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			w_busy     <= 1'b0;
			w_owner_wd <= 1'b0;
		end
		else if (awvalid && awready)
		begin
			w_busy     <= 1'b1;
			w_owner_wd <= aw_pick_wd;
		end
		else if (wvalid && wready && wlast)
			w_busy <= 1'b0;	// AW may open again after the burst
	end

	//--------------------------------------------------------------------
	// responses are always accepted
	//--------------------------------------------------------------------
	assign rready   = 1'b1;
	assign bready   = 1'b1;
	assign ln_r_hit = rvalid & (rid == bridge_pkg::id_line);
	assign wd_r_hit = rvalid & (rid == bridge_pkg::id_word);
	assign ln_b_hit = bvalid & (bid == bridge_pkg::id_line);
	assign wd_b_hit = bvalid & (bid == bridge_pkg::id_word);

endmodule

`default_nettype wire

/* src/dcache_axi_bridge.sv */
//--------------------------------------------------------------------
// data-side cache to AXI bridge, top level
// a line controller and a word controller feed one AXI master port
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_axi_bridge (
	input  logic                 clk,
	input  logic                 rst,
	// cached line port
	input  logic                 ln_rd_req,
	input  bridge_pkg::size_t    ln_rd_size,
	input  bridge_pkg::addr_t    ln_rd_addr,
	output logic                 ln_rd_rdy,
	output logic                 ln_ret_valid,
	output logic                 ln_ret_last,
	output bridge_pkg::word_t    ln_ret_data,
	input  logic                 ln_wr_req,
	input  bridge_pkg::size_t    ln_wr_size,
	input  bridge_pkg::addr_t    ln_wr_addr,
	input  bridge_pkg::strb_t    ln_wr_strb,
	input  bridge_pkg::line_t    ln_wr_data,
	output logic                 ln_wr_rdy,
	// uncached word port
	input  logic                 wd_rd_req,
	input  bridge_pkg::size_t    wd_rd_size,
	input  bridge_pkg::addr_t    wd_rd_addr,
	output logic                 wd_rd_rdy,
	output logic                 wd_ret_valid,
	output logic                 wd_ret_last,
	output bridge_pkg::word_t    wd_ret_data,
	input  logic                 wd_wr_req,
	input  bridge_pkg::size_t    wd_wr_size,
	input  bridge_pkg::addr_t    wd_wr_addr,
	input  bridge_pkg::strb_t    wd_wr_strb,
	input  bridge_pkg::word_t    wd_wr_data,
	output logic                 wd_wr_rdy,
	// AXI master
	output bridge_pkg::axi_id_t  arid,
	output bridge_pkg::addr_t    araddr,
	output bridge_pkg::len_t     arlen,
	output bridge_pkg::size_t    arsize,
	output logic                 arvalid,
	input  logic                 arready,
	input  bridge_pkg::axi_id_t  rid,
	input  bridge_pkg::word_t    rdata,
	input  logic                 rlast,
	input  logic                 rvalid,
	output logic                 rready,
	output bridge_pkg::axi_id_t  awid,
	output bridge_pkg::addr_t    awaddr,
	output bridge_pkg::len_t     awlen,
	output bridge_pkg::size_t    awsize,
	output logic                 awvalid,
	input  logic                 awready,
	output bridge_pkg::word_t    wdata,
	output bridge_pkg::strb_t    wstrb,
	output logic                 wlast,
	output logic                 wvalid,
	input  logic                 wready,
	input  bridge_pkg::axi_id_t  bid,
	input  logic                 bvalid,
	output logic                 bready
);

	//--------------------------------------------------------------------
	// controller to mux wiring
	//--------------------------------------------------------------------
	logic              ln_ar_valid, ln_aw_valid, ln_w_valid, ln_w_last;
	logic              ln_ar_ready, ln_aw_ready, ln_w_ready, ln_r_hit, ln_b_hit;
	bridge_pkg::addr_t ln_ar_addr, ln_aw_addr;
	bridge_pkg::size_t ln_ar_size, ln_aw_size;
	bridge_pkg::len_t  ln_ar_len, ln_aw_len;
	bridge_pkg::word_t ln_w_data;
	bridge_pkg::strb_t ln_w_strb;

	logic              wd_ar_valid, wd_aw_valid, wd_w_valid, wd_w_last;
	logic              wd_ar_ready, wd_aw_ready, wd_w_ready, wd_r_hit, wd_b_hit;
	bridge_pkg::addr_t wd_ar_addr, wd_aw_addr;
	bridge_pkg::size_t wd_ar_size, wd_aw_size;
	bridge_pkg::len_t  wd_ar_len, wd_aw_len;
	bridge_pkg::word_t wd_w_data;
	bridge_pkg::strb_t wd_w_strb;

	assign ln_ret_data = rdata;	// each port qualifies it with its own ret_valid
	assign wd_ret_data = rdata;

	port_channel #(.payload_t(bridge_pkg::line_t)) line_channel (
		.clk(clk), .rst(rst),
		.rd_req(ln_rd_req), .rd_size(ln_rd_size), .rd_addr(ln_rd_addr), .rd_rdy(ln_rd_rdy),
		.ret_valid(ln_ret_valid), .ret_last(ln_ret_last),
		.wr_req(ln_wr_req), .wr_size(ln_wr_size), .wr_addr(ln_wr_addr),
		.wr_strb(ln_wr_strb), .wr_data(ln_wr_data), .wr_rdy(ln_wr_rdy),
		.ar_valid(ln_ar_valid), .ar_addr(ln_ar_addr), .ar_size(ln_ar_size),
		.ar_len(ln_ar_len), .ar_ready(ln_ar_ready),
		.aw_valid(ln_aw_valid), .aw_addr(ln_aw_addr), .aw_size(ln_aw_size),
		.aw_len(ln_aw_len), .aw_ready(ln_aw_ready),
		.w_valid(ln_w_valid), .w_data(ln_w_data), .w_strb(ln_w_strb),
		.w_last(ln_w_last), .w_ready(ln_w_ready),
		.r_hit(ln_r_hit), .r_last(rlast), .b_hit(ln_b_hit)
	);

	port_channel #(.payload_t(bridge_pkg::word_t)) word_channel (
		.clk(clk), .rst(rst),
		.rd_req(wd_rd_req), .rd_size(wd_rd_size), .rd_addr(wd_rd_addr), .rd_rdy(wd_rd_rdy),
		.ret_valid(wd_ret_valid), .ret_last(wd_ret_last),
		.wr_req(wd_wr_req), .wr_size(wd_wr_size), .wr_addr(wd_wr_addr),
		.wr_strb(wd_wr_strb), .wr_data(wd_wr_data), .wr_rdy(wd_wr_rdy),
		.ar_valid(wd_ar_valid), .ar_addr(wd_ar_addr), .ar_size(wd_ar_size),
		.ar_len(wd_ar_len), .ar_ready(wd_ar_ready),
		.aw_valid(wd_aw_valid), .aw_addr(wd_aw_addr), .aw_size(wd_aw_size),
		.aw_len(wd_aw_len), .aw_ready(wd_aw_ready),
		.w_valid(wd_w_valid), .w_data(wd_w_data), .w_strb(wd_w_strb),
		.w_last(wd_w_last), .w_ready(wd_w_ready),
		.r_hit(wd_r_hit), .r_last(rlast), .b_hit(wd_b_hit)
	);

	// all mux ports share their names with nets of this scope
	axi_port_mux mux (.*);

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
//----------------------------------------------------------------------
// AXI slave memory model for the bridge testbench
// word memory with random ready stalls and bubbles on R and B
// read bursts are answered in order and carry their ID
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
	parameter int depth = 2048	// words
) (
	input  logic                 clk,
	input  logic                 rst,
	input  bridge_pkg::axi_id_t  arid,
	input  bridge_pkg::addr_t    araddr,
	input  bridge_pkg::len_t     arlen,
	input  logic                 arvalid,
	output logic                 arready,
	output bridge_pkg::axi_id_t  rid,
	output bridge_pkg::word_t    rdata,
	output logic                 rlast,
	output logic                 rvalid,
	input  logic                 rready,
	input  bridge_pkg::axi_id_t  awid,
	input  bridge_pkg::addr_t    awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  bridge_pkg::word_t    wdata,
	input  bridge_pkg::strb_t    wstrb,
	input  logic                 wlast,
	input  logic                 wvalid,
	output logic                 wready,
	output bridge_pkg::axi_id_t  bid,
	output logic                 bvalid,
	input  logic                 bready
);

	localparam int idx_bits = $clog2(depth);

	bridge_pkg::word_t    mem [depth];
	integer               seed = 38406;
	bridge_pkg::axi_id_t  rd_id_q [$];	// accepted read bursts, oldest first
	bridge_pkg::addr_t    rd_addr_q [$];
	bridge_pkg::len_t     rd_len_q [$];
	bridge_pkg::axi_id_t  wr_id_q [$];
	bridge_pkg::addr_t    wr_addr_q [$];	// advances by one word per W beat
	bridge_pkg::axi_id_t  b_id_q [$];
	bridge_pkg::addr_t    r_addr;
	int                   r_beat;
	int                   i;
	int                   b;

	function automatic logic [idx_bits-1:0] idx(input bridge_pkg::addr_t a);
		return a[idx_bits+1:2];
	endfunction

	// known start pattern, a function of the whole address
	function automatic bridge_pkg::word_t fill_word(input bridge_pkg::addr_t a);
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
	endfunction

	always @(posedge clk)
	begin
		if (!rst)
		begin
			for (i = 0; i < depth; i++)
				mem[i] = fill_word(bridge_pkg::addr_t'(i * 4));
			rd_id_q.delete();
			rd_addr_q.delete();
			rd_len_q.delete();
			wr_id_q.delete();
			wr_addr_q.delete();
			b_id_q.delete();
			r_beat = 0;
			arready <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			rid     <= '0;
			rdata   <= '0;
			bvalid  <= 1'b0;
			bid     <= '0;
		end
		else
		begin
			//----------------------------------------------------------------------
			// address and write data channels
			//----------------------------------------------------------------------
			if (arvalid && arready)
			begin
				rd_id_q.push_back(arid);
				rd_addr_q.push_back(araddr);
				rd_len_q.push_back(arlen);
			end
			if (awvalid && awready)
			begin
				wr_id_q.push_back(awid);
				wr_addr_q.push_back(awaddr);
			end
			if (wvalid && wready)
			begin
				for (b = 0; b < 4; b++)
					if (wstrb[b])
						mem[idx(wr_addr_q[0])][8*b +: 8] = wdata[8*b +: 8];
				wr_addr_q[0] = wr_addr_q[0] + 32'd4;
				if (wlast)
				begin
					b_id_q.push_back(wr_id_q.pop_front());	// burst done, answer on B
					void'(wr_addr_q.pop_front());
				end
			end
			arready <= ($random(seed) & 3) != 0;
			awready <= ($random(seed) & 3) != 0;
			wready  <= ($random(seed) & 3) != 0;

			//----------------------------------------------------------------------
			// read data and write response channels
			//----------------------------------------------------------------------
			if (rvalid && rready)
			begin
				if (rlast)
				begin
					void'(rd_id_q.pop_front());
					void'(rd_addr_q.pop_front());
					void'(rd_len_q.pop_front());
					r_beat = 0;
				end
				else
					r_beat = r_beat + 1;
			end
			if (rd_addr_q.size() != 0 && ($random(seed) & 3) != 0)
			begin
				r_addr = rd_addr_q[0] + bridge_pkg::addr_t'(r_beat * 4);
				rvalid <= 1'b1;
				rid    <= rd_id_q[0];
				rdata  <= mem[idx(r_addr)];
				rlast  <= (r_beat == int'(rd_len_q[0]));
			end
			else
				rvalid <= 1'b0;	// bubble

			if (bvalid && bready)
				void'(b_id_q.pop_front());
			if (b_id_q.size() != 0 && ($random(seed) & 1) != 0)
			begin
				bvalid <= 1'b1;
				bid    <= b_id_q[0];
			end
			else
				bvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* sim/bridge_tb.sv */
//----------------------------------------------------------------------
// testbench of the data-side AXI bridge
// runs both cache ports against a stalling AXI memory model and checks
// every returned beat and the AXI request fields against a shadow memory
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bridge_tb;

	localparam int mem_words = 2048;	// line addresses below 0x1000 and word addresses above
	localparam int idx_bits  = $clog2(mem_words);
	localparam int rand_ops  = 40;		// per port
	localparam int n_trans   = 10 + 2 * rand_ops;

	logic                 clk, rst;
	logic                 ln_rd_req, ln_rd_rdy, ln_ret_valid, ln_ret_last, ln_wr_req, ln_wr_rdy;
	logic                 wd_rd_req, wd_rd_rdy, wd_ret_valid, wd_ret_last, wd_wr_req, wd_wr_rdy;
	bridge_pkg::size_t    ln_rd_size, ln_wr_size, wd_rd_size, wd_wr_size, arsize, awsize;
	bridge_pkg::addr_t    ln_rd_addr, ln_wr_addr, wd_rd_addr, wd_wr_addr, araddr, awaddr;
	bridge_pkg::strb_t    ln_wr_strb, wd_wr_strb, wstrb;
	bridge_pkg::word_t    ln_ret_data, wd_ret_data, wd_wr_data, rdata, wdata;
	bridge_pkg::line_t    ln_wr_data;
	bridge_pkg::axi_id_t  arid, rid, awid, bid;
	bridge_pkg::len_t     arlen, awlen;
	logic                 arvalid, arready, rlast, rvalid, rready, awvalid, awready;
	logic                 wlast, wvalid, wready, bvalid, bready;

	integer               seed = 38406;
	bridge_pkg::word_t    shadow [mem_words];	// memory as the bridge should leave it
	bridge_pkg::addr_t    ln_pending [$];		// base address of each open line read
	bridge_pkg::addr_t    wd_pending [$];
	bridge_pkg::len_t     w_len_q [$];		// awlen of each open W burst
	int                   ln_beat = 0;
	int                   w_beat = 0;
	int                   i;
	logic                 ar_wait = 1'b0;
	logic                 aw_wait = 1'b0;
	logic                 w_wait = 1'b0;
	bridge_pkg::addr_t    ar_hold, aw_hold;
	bridge_pkg::word_t    w_hold;
	bridge_pkg::strb_t    w_hold_strb;
	logic                 w_hold_last;

	dcache_axi_bridge dut (.*);
	axi_mem_model #(.depth(mem_words)) mem_model (.*);

	//----------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------
	function automatic bridge_pkg::word_t init_word(input bridge_pkg::addr_t a);
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic bridge_pkg::word_t merge_word(input bridge_pkg::word_t old,
		input bridge_pkg::word_t nw, input bridge_pkg::strb_t strb);
		bridge_pkg::word_t r;
		int k;
		r = old;
		for (k = 0; k < 4; k++)
			if (strb[k])
				r[8*k +: 8] = nw[8*k +: 8];
		return r;
	endfunction

	function automatic int word_index(input bridge_pkg::addr_t a);
		return int'(a[idx_bits+1:2]);
	endfunction

	function automatic bridge_pkg::line_t random_line();
		bridge_pkg::line_t d;
		int k;
		for (k = 0; k < bridge_pkg::line_beats; k++)
			d[32*k +: 32] = $random(seed);
		return d;
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	//----------------------------------------------------------------------
	// stimulus driven 1 ns after a rising edge
	//----------------------------------------------------------------------
	task automatic after_edge();
		@(posedge clk);
		#1;
	endtask

	task automatic line_write(input bridge_pkg::addr_t a, input bridge_pkg::line_t d);
		int k;
		for (k = 0; k < bridge_pkg::line_beats; k++)
			shadow[word_index(a) + k] = d[32*k +: 32];
		while (!ln_wr_rdy)
			after_edge();
		ln_wr_req  = 1'b1;
		ln_wr_addr = a;
		ln_wr_data = d;
		ln_wr_size = 3'd2;
		ln_wr_strb = 4'hf;
		after_edge();
		ln_wr_req = 1'b0;
		while (!ln_wr_rdy)	// back to free after the B response
			after_edge();
	endtask

	task automatic word_write(input bridge_pkg::addr_t a, input bridge_pkg::word_t d,
		input bridge_pkg::strb_t strb);
		shadow[word_index(a)] = merge_word(shadow[word_index(a)], d, strb);
		while (!wd_wr_rdy)
			after_edge();
		wd_wr_req  = 1'b1;
		wd_wr_addr = a;
		wd_wr_data = d;
		wd_wr_size = 3'd2;
		wd_wr_strb = strb;
		after_edge();
		wd_wr_req = 1'b0;
		while (!wd_wr_rdy)
			after_edge();
	endtask

	task automatic line_read(input bridge_pkg::addr_t a);
		ln_pending.push_back(a);
		while (!ln_rd_rdy)
			after_edge();
		ln_rd_req  = 1'b1;
		ln_rd_addr = a;
		ln_rd_size = 3'd2;
		after_edge();
		ln_rd_req = 1'b0;
		while (!ln_rd_rdy)
			after_edge();
		check("open line reads", 32'(ln_pending.size()), 32'd0);
	endtask

	task automatic word_read(input bridge_pkg::addr_t a);
		wd_pending.push_back(a);
		while (!wd_rd_rdy)
			after_edge();
		wd_rd_req  = 1'b1;
		wd_rd_addr = a;
		wd_rd_size = 3'd2;
		after_edge();
		wd_rd_req = 1'b0;
		while (!wd_rd_rdy)
			after_edge();
		check("open word reads", 32'(wd_pending.size()), 32'd0);
	endtask

	task automatic random_line_ops(input int n);
		bridge_pkg::addr_t a;
		int k;
		for (k = 0; k < n; k++)
		begin
			a = bridge_pkg::addr_t'(({$random(seed)} % 64) * 64);
			if (($random(seed) & 1) != 0)
				line_write(a, random_line());
			else
				line_read(a);
		end
	endtask

	task automatic random_word_ops(input int n);
		bridge_pkg::addr_t a;
		int k;
		for (k = 0; k < n; k++)
		begin
			a = 32'h1000 + bridge_pkg::addr_t'(({$random(seed)} % 1024) * 4);
			if (($random(seed) & 1) != 0)
				word_write(a, $random(seed), bridge_pkg::strb_t'($random(seed)));
			else
				word_read(a);
		end
	endtask

	//----------------------------------------------------------------------
	// clock, watchdog and main sequence
	//----------------------------------------------------------------------
	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		repeat (n_trans * 200)
			@(posedge clk);
		stop_run($sformatf("timeout, %0d transactions not finished after %0d cycles",
			n_trans, n_trans * 200));
	end

	initial
	begin
		rst        = 1'b0;
		ln_rd_req  = 1'b0;
		ln_rd_size = '0;
		ln_rd_addr = '0;
		ln_wr_req  = 1'b0;
		ln_wr_size = '0;
		ln_wr_addr = '0;
		ln_wr_strb = '0;
		ln_wr_data = '0;
		wd_rd_req  = 1'b0;
		wd_rd_size = '0;
		wd_rd_addr = '0;
		wd_wr_req  = 1'b0;
		wd_wr_size = '0;
		wd_wr_addr = '0;
		wd_wr_strb = '0;
		wd_wr_data = '0;
		for (i = 0; i < mem_words; i++)
			shadow[i] = init_word(bridge_pkg::addr_t'(i * 4));
		repeat (10)
			@(posedge clk);
		#1;
		rst = 1'b1;

		@(negedge clk);	// idle state straight out of reset
		check("arvalid", 32'(arvalid), 32'd0);
		check("awvalid", 32'(awvalid), 32'd0);
		check("wvalid", 32'(wvalid), 32'd0);
		check("ln_ret_valid", 32'(ln_ret_valid), 32'd0);
		check("wd_ret_valid", 32'(wd_ret_valid), 32'd0);
		check("ln_rd_rdy", 32'(ln_rd_rdy), 32'd1);
		check("ln_wr_rdy", 32'(ln_wr_rdy), 32'd1);
		check("wd_rd_rdy", 32'(wd_rd_rdy), 32'd1);
		check("wd_wr_rdy", 32'(wd_wr_rdy), 32'd1);
		after_edge();

		word_write(32'h0000_1010, 32'hdead_beef, 4'b0101);	// partial strobe merge
		word_read(32'h0000_1010);
		line_write(32'h0000_0400, random_line());
		line_read(32'h0000_0400);
		fork
			line_read(32'h0000_0800);
			word_read(32'h0000_1020);
		join
		fork
			line_write(32'h0000_0c00, random_line());
			word_write(32'h0000_1040, $random(seed), 4'hf);
		join
		fork
			line_read(32'h0000_0c00);
			word_read(32'h0000_1040);
		join
		fork
			random_line_ops(rand_ops);
			random_word_ops(rand_ops);
		join
		$display("No errors");
		$finish;
	end

	//----------------------------------------------------------------------
	// returned beats compared with the shadow memory
	//----------------------------------------------------------------------
	initial
	forever
	begin
		@(negedge clk);
		if (rst)
		begin
			check("ln_ret_valid", 32'(ln_ret_valid), 32'(rvalid && rid == bridge_pkg::id_line));
			check("wd_ret_valid", 32'(wd_ret_valid), 32'(rvalid && rid == bridge_pkg::id_word));
			if (ln_ret_valid)
			begin
				check("line reads pending", 32'(ln_pending.size() != 0), 32'd1);
				check("ln_ret_data", ln_ret_data, shadow[word_index(ln_pending[0]) + ln_beat]);
				check("ln_ret_last", 32'(ln_ret_last),
					32'(ln_beat == bridge_pkg::line_beats - 1));
				if (ln_ret_last)
				begin
					void'(ln_pending.pop_front());
					ln_beat = 0;
				end
				else
					ln_beat = ln_beat + 1;
			end
			if (wd_ret_valid)
			begin
				check("word reads pending", 32'(wd_pending.size() != 0), 32'd1);
				check("wd_ret_data", wd_ret_data, shadow[word_index(wd_pending[0])]);
				check("wd_ret_last", 32'(wd_ret_last), 32'd1);
				void'(wd_pending.pop_front());
			end
		end
	end

	//----------------------------------------------------------------------
	// AXI request checks for held fields under stall and for burst shape
	//----------------------------------------------------------------------
	initial
	forever
	begin
		@(negedge clk);
		if (rst)
		begin
			check("rready", 32'(rready), 32'd1);
			check("bready", 32'(bready), 32'd1);
			if (ar_wait)
			begin
				check("arvalid", 32'(arvalid), 32'd1);
				check("araddr", araddr, ar_hold);
			end
			if (aw_wait)
			begin
				check("awvalid", 32'(awvalid), 32'd1);
				check("awaddr", awaddr, aw_hold);
			end
			if (w_wait)
			begin
				check("wvalid", 32'(wvalid), 32'd1);
				check("wdata", wdata, w_hold);
				check("wstrb", 32'(wstrb), 32'(w_hold_strb));
				check("wlast", 32'(wlast), 32'(w_hold_last));
			end
			if (arvalid && arready)
			begin
				check("arlen", 32'(arlen), (arid == bridge_pkg::id_line) ?
					32'(bridge_pkg::line_beats - 1) : 32'd0);
				check("arsize", 32'(arsize), 32'd2);
			end
			if (awvalid && awready)
			begin
				check("awlen", 32'(awlen), (awid == bridge_pkg::id_line) ?
					32'(bridge_pkg::line_beats - 1) : 32'd0);
				check("awsize", 32'(awsize), 32'd2);
				w_len_q.push_back(awlen);
			end
			if (wvalid && wready)
			begin
				check("open write bursts", 32'(w_len_q.size() != 0), 32'd1);
				check("wlast", 32'(wlast), 32'(w_beat == int'(w_len_q[0])));
				if (wlast)
				begin
					void'(w_len_q.pop_front());
					w_beat = 0;
				end
				else
					w_beat = w_beat + 1;
			end
			ar_wait     = arvalid & ~arready;	// a stalled channel must hold in the next cycle
			ar_hold     = araddr;
			aw_wait     = awvalid & ~awready;
			aw_hold     = awaddr;
			w_wait      = wvalid & ~wready;
			w_hold      = wdata;
			w_hold_strb = wstrb;
			w_hold_last = wlast;
		end
	end

endmodule

`default_nettype wire

/* dcache_axi_bridge.f */
src/bridge_pkg.sv
src/port_channel.sv
src/axi_port_mux.sv
src/dcache_axi_bridge.sv
sim/axi_mem_model.sv
sim/bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the bridge and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module bridge_tb -f dcache_axi_bridge.f -o bridge_sim

out=$(./obj_dir/bridge_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "No errors"
then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
